// ==== verification/addressPath_patterns.txt ====
// Columns: instrD instrE ctrl addrExp hazExp
// ctrl digits: multSelectD regSrcD regFileRzD writeMultLoE stallE stallM stallW flushW
// addrExp: RA1D RA2D WA3W, two digits each
// hazExp digits: match1EM match1EW match2EM match2EW match1DE match2DE forwardAE forwardBE
// Decode selection, regSrcD 0..3 with bank bits
E0123A04 00000000 00000000 020400 11110022
E0123A04 00000000 01100000 1F0400 00000000
E0123A04 00000000 02200000 021300 00000000
E0123A04 00000000 03400000 0F0303 00000100
// Multiply forms
E0050697 00000000 10700000 171603 00110002
E0050697 00000000 13000000 070603 00000000
E0050697 00000000 11000000 070613 00000000
E0050697 00000000 12000000 070615 00000000
// Register-shifted register operand
E0123A14 00000000 00000000 0A0405 00000000
E0123A14 00000000 03300000 1A1305 00000000
// Stall of execute and memory, then flush
E0819004 00000000 00400000 010405 00000000
E0123A04 00000000 00000000 020403 00000000
E0123A04 00000000 00001100 020403 00000000
E0123A04 00000000 00001100 020419 00000000
E0123A04 00000000 00000001 020419 00000000
E0123A04 00000000 00000000 020400 00000000
E0123A04 00000000 00000011 020403 00000000
E0123A04 00000000 00000000 020400 00000000
// Long multiply RdLo override
E0050697 00007000 10010000 070603 00001000
E0123A04 00000000 00000000 020403 10000020
E0123A04 00000000 00000000 020407 00000000
// Forwarding priority and decode matches
E0033003 00000000 00000000 030305 00001100
E0819004 00000000 00000000 010403 11110022
E0033003 00000000 00000000 030303 00000000
E0123A04 00000000 00000000 020403 01010011
E0123A04 00000000 00000000 020409 00000000

// ==== filelist.f ====
+incdir+include
rtl/addressPathPkg.sv
rtl/regAddrIf.sv
rtl/regAddrDecode.sv
rtl/regAddrPipeline.sv
rtl/hazardCompare.sv
rtl/addressPath.sv
verification/addressPathTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the address path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module addressPathTb -Mdir obj_dir -f filelist.f
./obj_dir/VaddressPathTb | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== verification/addressPathTb.sv ====
`timescale 1ns/1ps

module addressPathTb;

  localparam int NumPat = 26;
  localparam int WordsPerPat = 5;
  localparam int ClkPeriod = 8;

  logic clk;
  logic reset;
  addressPathPkg::instrT instrD;
  addressPathPkg::instrT instrE;
  logic multSelectD;
  logic [1:0] regSrcD;
  logic [2:0] regFileRzD;
  logic writeMultLoE;
  logic stallE;
  logic stallM;
  logic stallW;
  logic flushW;
  addressPathPkg::regAddrT RA1D;
  addressPathPkg::regAddrT RA2D;
  addressPathPkg::regAddrT WA3W;
  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  logic match1DE;
  logic match2DE;
  addressPathPkg::fwdSelT forwardAE;
  addressPathPkg::fwdSelT forwardBE;

  // Five words per cycle: instrD, instrE, controls, addresses, hazard outputs
  logic [31:0] patMem [0:NumPat*WordsPerPat-1];

  int errorCount;
  int checkCount;

  addressPath addressPath_i (
    .clk          (clk),
    .reset        (reset),
    .instrD       (instrD),
    .instrE       (instrE),
    .multSelectD  (multSelectD),
    .regSrcD      (regSrcD),
    .regFileRzD   (regFileRzD),
    .writeMultLoE (writeMultLoE),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .RA1D         (RA1D),
    .RA2D         (RA2D),
    .WA3W         (WA3W),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .match1DE     (match1DE),
    .match2DE     (match2DE),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE)
  );

  // ==========================================================================
  // Clock and watchdog
  // ==========================================================================
  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  // Reset cycles and slack fit inside the extra ten periods
  initial begin
    #((NumPat + 10) * ClkPeriod);
    $display("Watchdog expired before all patterns were checked");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ==========================================================================
  // Stimulus and checking
  // ==========================================================================
  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected, input int pat);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("Fail %s got %0h expected %0h at pattern %0d", name, got, expected, pat);
    end
  endtask

  // Control word holds one field per hex digit
  task automatic applyPattern(input int pat);
    logic [31:0] ctrl;
    ctrl         = patMem[pat*WordsPerPat + 2];
    instrD       = patMem[pat*WordsPerPat];
    instrE       = patMem[pat*WordsPerPat + 1];
    multSelectD  = ctrl[28];
    regSrcD      = ctrl[25:24];
    regFileRzD   = ctrl[22:20];
    writeMultLoE = ctrl[16];
    stallE       = ctrl[12];
    stallM       = ctrl[8];
    stallW       = ctrl[4];
    flushW       = ctrl[0];
  endtask

  task automatic checkPattern(input int pat);
    logic [31:0] addrExp;
    logic [31:0] hazExp;
    addrExp = patMem[pat*WordsPerPat + 3];
    hazExp  = patMem[pat*WordsPerPat + 4];
    checkValue("RA1D", 32'(RA1D), 32'(addrExp[23:16]), pat);
    checkValue("RA2D", 32'(RA2D), 32'(addrExp[15:8]), pat);
    checkValue("WA3W", 32'(WA3W), 32'(addrExp[7:0]), pat);
    checkValue("match1EM", 32'(match1EM), 32'(hazExp[28]), pat);
    checkValue("match1EW", 32'(match1EW), 32'(hazExp[24]), pat);
    checkValue("match2EM", 32'(match2EM), 32'(hazExp[20]), pat);
    checkValue("match2EW", 32'(match2EW), 32'(hazExp[16]), pat);
    checkValue("match1DE", 32'(match1DE), 32'(hazExp[12]), pat);
    checkValue("match2DE", 32'(match2DE), 32'(hazExp[8]), pat);
    checkValue("forwardAE", 32'(forwardAE), 32'(hazExp[5:4]), pat);
    checkValue("forwardBE", 32'(forwardBE), 32'(hazExp[1:0]), pat);
  endtask

  initial begin
    int pat;
    errorCount   = 0;
    checkCount   = 0;
    reset        = 1'b1;
    instrD       = '0;
    instrE       = '0;
    multSelectD  = 1'b0;
    regSrcD      = '0;
    regFileRzD   = '0;
    writeMultLoE = 1'b0;
    stallE       = 1'b0;
    stallM       = 1'b0;
    stallW       = 1'b0;
    flushW       = 1'b0;
    $readmemh("verification/addressPath_patterns.txt", patMem);
    // First instruction word is never zero in a loaded file
    if (patMem[0] == 32'h0) begin
      errorCount++;
      $display("Pattern file did not load");
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // Drive 1 ns after the edge, sample 1 ns before the next
    for (pat = 0; pat < NumPat; pat++) begin
      applyPattern(pat);
      #(ClkPeriod - 2);
      checkPattern(pat);
      @(posedge clk);
      #1;
    end
    $display("Checks run: %0d  errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/addressPath.sv ====
`timescale 1ns/1ps

module addressPath (
  input  logic                    clk,
  input  logic                    reset,
  input  addressPathPkg::instrT   instrD,
  input  addressPathPkg::instrT   instrE,
  input  logic                    multSelectD,
  input  logic [1:0]              regSrcD,
  input  logic [2:0]              regFileRzD,
  input  logic                    writeMultLoE,
  input  logic                    stallE,
  input  logic                    stallM,
  input  logic                    stallW,
  input  logic                    flushW,
  output addressPathPkg::regAddrT RA1D,
  output addressPathPkg::regAddrT RA2D,
  output addressPathPkg::regAddrT WA3W,
  output logic                    match1EM,
  output logic                    match1EW,
  output logic                    match2EM,
  output logic                    match2EW,
  output logic                    match1DE,
  output logic                    match2DE,
  output addressPathPkg::fwdSelT  forwardAE,
  output addressPathPkg::fwdSelT  forwardBE
);

  // Decoded destination into execute
  addressPathPkg::regAddrT destD;

  // Stage addresses shared by pipeline and comparator
  regAddrIf addrIf ();

  // ==========================================================================
  // Decode
  // ==========================================================================
  regAddrDecode uDecode (
    .instrD      (instrD),
    .multSelectD (multSelectD),
    .regSrcD     (regSrcD),
    .regFileRzD  (regFileRzD),
    .ra1D        (RA1D),
    .ra2D        (RA2D),
    .destD       (destD)
  );

  // ==========================================================================
  // Execute, memory, writeback
  // ==========================================================================
  regAddrPipeline uPipeline (
    .clk          (clk),
    .reset        (reset),
    .stallE       (stallE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .writeMultLoE (writeMultLoE),
    .instrE       (instrE),
    .ra1D         (RA1D),
    .ra2D         (RA2D),
    .destD        (destD),
    .stage        (addrIf.stage)
  );

  // Register file write port
  assign WA3W = addrIf.wa3W;

  // ==========================================================================
  // Hazard comparison
  // ==========================================================================
  hazardCompare uHazard (
    .hazard    (addrIf.hazard),
    .ra1D      (RA1D),
    .ra2D      (RA2D),
    .match1EM  (match1EM),
    .match1EW  (match1EW),
    .match2EM  (match2EM),
    .match2EW  (match2EW),
    .match1DE  (match1DE),
    .match2DE  (match2DE),
    .forwardAE (forwardAE),
    .forwardBE (forwardBE)
  );

endmodule

// ==== rtl/hazardCompare.sv ====
`timescale 1ns/1ps

module hazardCompare (
  regAddrIf.hazard                hazard,
  input  addressPathPkg::regAddrT ra1D,
  input  addressPathPkg::regAddrT ra2D,
  output logic                    match1EM,
  output logic                    match1EW,
  output logic                    match2EM,
  output logic                    match2EW,
  output logic                    match1DE,
  output logic                    match2DE,
  output addressPathPkg::fwdSelT  forwardAE,
  output addressPathPkg::fwdSelT  forwardBE
);

  // Newest producer wins, memory before writeback
  function automatic addressPathPkg::fwdSelT pickFwd(
    input logic matchM,
    input logic matchW
  );
    addressPathPkg::fwdSelT sel;
    if (matchM) begin
      sel = addressPathPkg::fwdMemory;
    end else if (matchW) begin
      sel = addressPathPkg::fwdWriteback;
    end else begin
      sel = addressPathPkg::fwdRegFile;
    end
    return sel;
  endfunction

  // Execute sources against older destinations
  assign match1EM = (hazard.ra1E == hazard.wa3M);
  assign match1EW = (hazard.ra1E == hazard.wa3W);
  assign match2EM = (hazard.ra2E == hazard.wa3M);
  assign match2EW = (hazard.ra2E == hazard.wa3W);

  // Decode sources against execute destination
  // Feeds the load-use stall check
  assign match1DE = (ra1D == hazard.wa3E);
  assign match2DE = (ra2D == hazard.wa3E);

  assign forwardAE = pickFwd(match1EM, match1EW);
  assign forwardBE = pickFwd(match2EM, match2EW);

  // Encoding 3 has no source behind it in the operand mux
  always_comb begin
    assert ((forwardAE != 2'd3) && (forwardBE != 2'd3))
      else $error("hazardCompare: forward select of 3");
  end

endmodule

// ==== rtl/regAddrPipeline.sv ====
`timescale 1ns/1ps

module regAddrPipeline (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stallE,
  input  logic                    stallM,
  input  logic                    stallW,
  input  logic                    flushW,
  input  logic                    writeMultLoE,
  input  addressPathPkg::instrT   instrE,
  input  addressPathPkg::regAddrT ra1D,
  input  addressPathPkg::regAddrT ra2D,
  input  addressPathPkg::regAddrT destD,
  regAddrIf.stage                 stage
);

  // Decoded destination as it entered execute
  addressPathPkg::regAddrT destE;

  // Low half destination of a long multiply
  addressPathPkg::regAddrT rdLoE;

  // ==========================================================================
  // Execute stage
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      stage.ra1E <= '0;
      stage.ra2E <= '0;
      destE      <= '0;
    end else if (!stallE) begin
      stage.ra1E <= ra1D;
      stage.ra2E <= ra2D;
      destE      <= destD;
    end
  end

  // RdLo lives in bits 15:12, always in bank 0
  assign rdLoE = {1'b0, instrE[15:12]};

  // Second write of a long multiply retargets the destination
  assign stage.wa3E = writeMultLoE ? rdLoE : destE;

  // ==========================================================================
  // Memory stage
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      stage.wa3M <= '0;
    end else if (!stallM) begin
      stage.wa3M <= stage.wa3E;
    end
  end

  // ==========================================================================
  // Writeback stage
  // ==========================================================================
  // Flush wins over both stall and load
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      stage.wa3W <= '0;
    end else if (!stallW) begin
      stage.wa3W <= stage.wa3M;
    end
  end

  // Flushed writeback never targets a live register
  wbFlushClears: assert property (
    @(posedge clk) disable iff (reset)
    flushW |=> (stage.wa3W == '0)
  ) else $error("regAddrPipeline: wa3W not cleared after flushW");

endmodule

// ==== rtl/regAddrDecode.sv ====
`timescale 1ns/1ps
`include "addressPath_config.svh"

module regAddrDecode (
  input  addressPathPkg::instrT   instrD,
  input  logic                    multSelectD,
  input  logic [1:0]              regSrcD,
  input  logic [2:0]              regFileRzD,
  output addressPathPkg::regAddrT ra1D,
  output addressPathPkg::regAddrT ra2D,
  output addressPathPkg::regAddrT destD
);

  // Register fields of the instruction
  addressPathPkg::regIdxT rnD;
  addressPathPkg::regIdxT rdD;
  addressPathPkg::regIdxT rsD;
  addressPathPkg::regIdxT rmD;
  addressPathPkg::regIdxT mulDestD;

  // Selected register numbers before the bank bit
  addressPathPkg::regIdxT ra1IdxD;
  addressPathPkg::regIdxT ra2IdxD;
  addressPathPkg::regIdxT destIdxD;

  logic regShiftD;

  // ==========================================================================
  // Field extraction
  // ==========================================================================
  assign rnD = instrD[19:16];
  assign rdD = instrD[15:12];
  assign rsD = instrD[11:8];
  assign rmD = instrD[3:0];

  // Multiplies put Rd in the Rn slot
  assign mulDestD = instrD[19:16];

  // Data processing, register-shifted register operand
  // Bit 7 low and bit 4 high, multiplies have bit 7 high
  assign regShiftD = (instrD[27:25] == 3'b000) && !instrD[7] && instrD[4];

  // ==========================================================================
  // Read and write address selection
  // ==========================================================================
  // RA1 priority: multiply Rm, then shift amount Rs, then PC, then Rn
  always_comb begin
    if (multSelectD) begin
      ra1IdxD = rmD;
    end else if (regShiftD) begin
      ra1IdxD = rsD;
    end else if (regSrcD[0]) begin
      ra1IdxD = addressPathPkg::regIdxT'(`PC_REG_IDX);
    end else begin
      ra1IdxD = rnD;
    end
  end

  // RA2 is Rs for multiplies, Rd for stores, else Rm
  always_comb begin
    if (multSelectD) begin
      ra2IdxD = rsD;
    end else if (regSrcD[1]) begin
      ra2IdxD = rdD;
    end else begin
      ra2IdxD = rmD;
    end
  end

  assign destIdxD = multSelectD ? mulDestD : rdD;

  // Bank bits, one per port
  assign ra1D  = {regFileRzD[0], ra1IdxD};
  assign ra2D  = {regFileRzD[1], ra2IdxD};
  assign destD = {regFileRzD[2], destIdxD};

  // Known selects and instruction must give known addresses
  always_comb begin
    if (!$isunknown({instrD, multSelectD, regSrcD, regFileRzD})) begin
      assert (!$isunknown({ra1D, ra2D, destD}))
        else $error("regAddrDecode: unknown register address from known inputs");
    end
  end

endmodule

// ==== rtl/regAddrIf.sv ====
`timescale 1ns/1ps

// Register addresses held in the execute, memory and writeback stages
interface regAddrIf;

  // Destination of the instruction in execute
  // Already carries the long multiply RdLo override
  addressPathPkg::regAddrT wa3E;

  // Destination in memory
  addressPathPkg::regAddrT wa3M;

  // Destination in writeback, also the register file write port
  addressPathPkg::regAddrT wa3W;

  // Source addresses of the instruction in execute
  addressPathPkg::regAddrT ra1E;
  addressPathPkg::regAddrT ra2E;

  // Pipeline registers own every signal
  modport stage (
    output wa3E, wa3M, wa3W, ra1E, ra2E
  );

  // Comparator side only looks
  modport hazard (
    input wa3E, wa3M, wa3W, ra1E, ra2E
  );

endinterface

// ==== rtl/addressPathPkg.sv ====
`include "addressPath_config.svh"

package addressPathPkg;

  // Full instruction word
  typedef logic [`INSTR_WIDTH-1:0] instrT;

  // Architectural register number R0..R15
  typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

  // Physical register address
  // MSB is the bank bit, low bits the register number
  typedef logic [`REG_IDX_WIDTH:0] regAddrT;

  // Forwarding mux select for an execute operand
  typedef logic [1:0] fwdSelT;

  // Operand straight from the register file
  localparam fwdSelT fwdRegFile = 2'd0;
  // Result of the writeback stage
  localparam fwdSelT fwdWriteback = 2'd1;
  // ALU result held in the memory stage
  localparam fwdSelT fwdMemory = 2'd2;

endpackage

// ==== include/addressPath_config.svh ====
`ifndef ADDRESSPATH_CONFIG_SVH
`define ADDRESSPATH_CONFIG_SVH

// Instruction word width
`define INSTR_WIDTH 32

// Architectural register number width
// Bank bit is added on top of this
`define REG_IDX_WIDTH 4

// R15 reads as the PC
`define PC_REG_IDX 15

`endif
